// File: aurora_link_pkg.sv
package aurora_link_pkg;

    // stream word and register width
    localparam int DATA_W     = 32;
    localparam int KEEP_W     = 4;
    // byte address, bits 4:2 pick the register
    localparam int REG_ADDR_W = 5;

    localparam logic [2:0] REG_CONTROL  = 3'd0;
    localparam logic [2:0] REG_STATUS   = 3'd1;
    localparam logic [2:0] REG_EYESCAN  = 3'd2;
    localparam logic [2:0] REG_DMONITOR = 3'd3;
    localparam logic [2:0] REG_UPTIME   = 3'd4;

    // ufc size code, one 32-bit word
    localparam logic [2:0] UFC_SIZE_ONE_WORD  = 3'd1;
    localparam logic [3:0] TXDIFFCTRL_DEFAULT = 4'd8;

    typedef struct packed {
        logic        err_clear;
        logic [23:0] rsvd_30_7;
        logic [2:0]  loopback;
        logic        powerdown;
        logic        rsvd_2;
        logic        gt_reset;
        logic        link_reset;
    } ctrl_fields_t;

    typedef struct packed {
        logic [10:0] rsvd_31_21;
        logic [4:0]  postcursor;
        logic [2:0]  rsvd_15_13;
        logic [4:0]  precursor;
        logic [3:0]  rsvd_7_4;
        logic [3:0]  swing;
    } eyescan_fields_t;

    // same bus word, decoded by register address
    typedef union packed {
        logic [DATA_W-1:0] raw;
        ctrl_fields_t      ctrl;
        eyescan_fields_t   eyescan;
    } reg_word_u;

endpackage

// File: aurora_link_sva.sv
`timescale 1ns/10ps

module aurora_link_sva (
    input logic user_clk,
    input logic linkerr_reset_userclk,
    input logic wb_ack_o,
    input logic m_ufc_tvalid_o,
    input logic m_ufc_tready_i,
    input logic s_ufc_tready_o,
    input logic s_axis_tvalid_i,
    input logic s_axis_tready_o
);

    // ack lasts a single cycle
    ack_one_cycle: assert property (@(posedge user_clk) disable iff (linkerr_reset_userclk)
        wb_ack_o |=> !wb_ack_o)
        else $error("wb_ack_o held for more than one cycle");

    // ufc pop only right after a request handshake
    ufc_pop_after_req: assert property (@(posedge user_clk) disable iff (linkerr_reset_userclk)
        s_ufc_tready_o |-> $past(m_ufc_tvalid_o && m_ufc_tready_i))
        else $error("s_ufc_tready_o high without a preceding request handshake");

    // data lane is borrowed in the ufc cycle
    no_beat_in_ufc_cycle: assert property (@(posedge user_clk) disable iff (linkerr_reset_userclk)
        s_ufc_tready_o |-> !(s_axis_tvalid_i && s_axis_tready_o))
        else $error("data beat accepted during the ufc data cycle");

endmodule

bind aurora_link_top aurora_link_sva u_sva (
    .user_clk(user_clk), .linkerr_reset_userclk(linkerr_reset_userclk),
    .wb_ack_o(wb_ack_o), .m_ufc_tvalid_o(m_ufc_tvalid_o), .m_ufc_tready_i(m_ufc_tready_i),
    .s_ufc_tready_o(s_ufc_tready_o), .s_axis_tvalid_i(s_axis_tvalid_i),
    .s_axis_tready_o(s_axis_tready_o)
);

// File: aurora_link_top.sv
`timescale 1ns/10ps

module aurora_link_top #(
    parameter int DATA_W   = aurora_link_pkg::DATA_W,
    parameter int UPTIME_W = DATA_W
) (
    input  logic                                   user_clk,
    input  logic                                   linkerr_reset_userclk,
    input  logic                                   wb_cyc_i,
    input  logic                                   wb_stb_i,
    input  logic                                   wb_we_i,
    input  logic [3:0]                             wb_sel_i,
    input  logic [aurora_link_pkg::REG_ADDR_W-1:0] wb_adr_i,
    input  logic [aurora_link_pkg::DATA_W-1:0]     wb_dat_i,
    output logic                                   wb_ack_o,
    output logic [aurora_link_pkg::DATA_W-1:0]     wb_dat_o,
    input  logic                                   hsk_rst_i,
    output logic                                   lane_up_o,
    output logic [3:0]                             hsk_stat_o,
    input  logic                                   pps_i,
    input  logic                                   lane_up_i,
    input  logic                                   channel_up_i,
    input  logic                                   tx_lock_i,
    input  logic                                   tx_resetdone_i,
    input  logic                                   rx_resetdone_i,
    input  logic                                   hard_err_i,
    input  logic                                   soft_err_i,
    input  logic                                   frame_err_i,
    input  logic [15:0]                            dmonitor_i,
    input  logic [DATA_W-1:0]                      s_axis_tdata_i,
    input  logic [aurora_link_pkg::KEEP_W-1:0]     s_axis_tkeep_i,
    input  logic                                   s_axis_tlast_i,
    input  logic                                   s_axis_tvalid_i,
    output logic                                   s_axis_tready_o,
    input  logic [DATA_W-1:0]                      s_ufc_tdata_i,
    input  logic                                   s_ufc_tvalid_i,
    output logic                                   s_ufc_tready_o,
    output logic [DATA_W-1:0]                      m_tx_tdata_o,
    output logic [aurora_link_pkg::KEEP_W-1:0]     m_tx_tkeep_o,
    output logic                                   m_tx_tlast_o,
    output logic                                   m_tx_tvalid_o,
    input  logic                                   m_tx_tready_i,
    output logic [2:0]                             m_ufc_tdata_o,
    output logic                                   m_ufc_tvalid_o,
    input  logic                                   m_ufc_tready_i,
    output logic                                   link_reset_o,
    output logic                                   gt_reset_o,
    output logic                                   powerdown_o,
    output logic [2:0]                             loopback_o,
    output logic [3:0]                             txdiffctrl_o,
    output logic [4:0]                             txprecursor_o,
    output logic [4:0]                             txpostcursor_o
);

    logic                                err_clear;
    logic [aurora_link_pkg::DATA_W-1:0] status_word;
    logic [UPTIME_W-1:0]                uptime;

    link_ctrl_regs u_regs (
        .user_clk(user_clk), .linkerr_reset_userclk(linkerr_reset_userclk),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_sel_i(wb_sel_i), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
        .hsk_rst_i(hsk_rst_i), .status_i(status_word), .dmonitor_i(dmonitor_i),
        .uptime_i(uptime), .wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o),
        .link_reset_o(link_reset_o), .gt_reset_o(gt_reset_o),
        .powerdown_o(powerdown_o), .loopback_o(loopback_o), .err_clear_o(err_clear),
        .txdiffctrl_o(txdiffctrl_o), .txprecursor_o(txprecursor_o),
        .txpostcursor_o(txpostcursor_o)
    );

    // link reset status bit reflects the reset driven toward the core
    link_status_capture u_status (
        .user_clk(user_clk), .linkerr_reset_userclk(linkerr_reset_userclk),
        .err_clear_i(err_clear), .lane_up_i(lane_up_i), .channel_up_i(channel_up_i),
        .tx_lock_i(tx_lock_i), .tx_resetdone_i(tx_resetdone_i),
        .rx_resetdone_i(rx_resetdone_i), .link_reset_i(link_reset_o),
        .hard_err_i(hard_err_i), .soft_err_i(soft_err_i), .frame_err_i(frame_err_i),
        .status_o(status_word), .lane_up_o(lane_up_o), .hsk_stat_o(hsk_stat_o)
    );

    link_uptime_counter #(.UPTIME_W(UPTIME_W)) u_uptime (
        .user_clk(user_clk), .linkerr_reset_userclk(linkerr_reset_userclk),
        .pps_i(pps_i), .tx_ready_i(m_tx_tready_i), .uptime_o(uptime)
    );

    link_tx_arbiter #(.DATA_W(DATA_W)) u_tx_arb (
        .user_clk(user_clk), .linkerr_reset_userclk(linkerr_reset_userclk),
        .s_axis_tdata_i(s_axis_tdata_i), .s_axis_tkeep_i(s_axis_tkeep_i),
        .s_axis_tlast_i(s_axis_tlast_i), .s_axis_tvalid_i(s_axis_tvalid_i),
        .s_axis_tready_o(s_axis_tready_o), .s_ufc_tdata_i(s_ufc_tdata_i),
        .s_ufc_tvalid_i(s_ufc_tvalid_i), .s_ufc_tready_o(s_ufc_tready_o),
        .m_tx_tdata_o(m_tx_tdata_o), .m_tx_tkeep_o(m_tx_tkeep_o),
        .m_tx_tlast_o(m_tx_tlast_o), .m_tx_tvalid_o(m_tx_tvalid_o),
        .m_tx_tready_i(m_tx_tready_i), .m_ufc_tdata_o(m_ufc_tdata_o),
        .m_ufc_tvalid_o(m_ufc_tvalid_o), .m_ufc_tready_i(m_ufc_tready_i)
    );

endmodule

// File: link_ctrl_regs.sv
`timescale 1ns/10ps

module link_ctrl_regs (
    input  logic                                   user_clk,
    input  logic                                   linkerr_reset_userclk,
    input  logic                                   wb_cyc_i,
    input  logic                                   wb_stb_i,
    input  logic                                   wb_we_i,
    input  logic [3:0]                             wb_sel_i,
    input  logic [aurora_link_pkg::REG_ADDR_W-1:0] wb_adr_i,
    input  logic [aurora_link_pkg::DATA_W-1:0]     wb_dat_i,
    input  logic                                   hsk_rst_i,
    input  logic [aurora_link_pkg::DATA_W-1:0]     status_i,
    input  logic [15:0]                            dmonitor_i,
    input  logic [aurora_link_pkg::DATA_W-1:0]     uptime_i,
    output logic                                   wb_ack_o,
    output logic [aurora_link_pkg::DATA_W-1:0]     wb_dat_o,
    output logic                                   link_reset_o,
    output logic                                   gt_reset_o,
    output logic                                   powerdown_o,
    output logic [2:0]                             loopback_o,
    output logic                                   err_clear_o,
    output logic [3:0]                             txdiffctrl_o,
    output logic [4:0]                             txprecursor_o,
    output logic [4:0]                             txpostcursor_o
);
    import aurora_link_pkg::*;

    typedef enum logic {ST_IDLE, ST_ACK} wb_state_t;

    wb_state_t         state_q;
    logic              req;
    logic              wr_ack;
    logic [2:0]        reg_idx;
    logic [2:0]        base_idx;
    reg_word_u         wr_word;
    ctrl_fields_t      ctrl_rd;
    eyescan_fields_t   eyescan_rd;
    logic [DATA_W-1:0] rd_data;

    assign req      = wb_cyc_i && wb_stb_i;
    assign wb_ack_o = (state_q == ST_ACK);
    // write lands on the edge that closes the ack cycle
    assign wr_ack   = wb_ack_o && req && wb_we_i;
    assign reg_idx  = wb_adr_i[4:2];
    // 5..7 fold back onto status, eye-scan and dmonitor
    assign base_idx = (reg_idx > REG_UPTIME) ? reg_idx - 3'd4 : reg_idx;
    assign wr_word  = wb_dat_i;

    always_comb begin
        ctrl_rd            = '0;
        ctrl_rd.link_reset = link_reset_o;
        ctrl_rd.gt_reset   = gt_reset_o;
        ctrl_rd.powerdown  = powerdown_o;
        ctrl_rd.loopback   = loopback_o;
        ctrl_rd.err_clear  = err_clear_o;
        eyescan_rd            = '0;
        eyescan_rd.swing      = txdiffctrl_o;
        eyescan_rd.precursor  = txprecursor_o;
        eyescan_rd.postcursor = txpostcursor_o;
    end

    always_comb begin
        case (base_idx)
            REG_CONTROL:  rd_data = ctrl_rd;
            REG_STATUS:   rd_data = status_i;
            REG_EYESCAN:  rd_data = eyescan_rd;
            REG_DMONITOR: rd_data = {{(DATA_W-16){1'b0}}, dmonitor_i};
            REG_UPTIME:   rd_data = uptime_i;
            default:      rd_data = '0;
        endcase
    end

    // read data sampled on the request cycle, shown during ack
    always_ff @(posedge user_clk) begin
        if (state_q == ST_IDLE && req && !wb_we_i) begin
            wb_dat_o <= rd_data;
        end
    end

    always_ff @(posedge user_clk) begin
        if (linkerr_reset_userclk) begin
            state_q        <= ST_IDLE;
            link_reset_o   <= 1'b0;
            gt_reset_o     <= 1'b0;
            powerdown_o    <= 1'b0;
            loopback_o     <= 3'd0;
            err_clear_o    <= 1'b0;
            txdiffctrl_o   <= TXDIFFCTRL_DEFAULT;
            txprecursor_o  <= 5'd0;
            txpostcursor_o <= 5'd0;
        end else begin
            case (state_q)
                ST_IDLE: if (req) state_q <= ST_ACK;
                default: state_q <= ST_IDLE;
            endcase
            // housekeeping owns link reset unless a write is landing
            if (!wr_ack) begin
                link_reset_o <= hsk_rst_i;
            end else if (reg_idx == REG_CONTROL && wb_sel_i[0]) begin
                link_reset_o <= wr_word.ctrl.link_reset;
            end
            if (wr_ack && reg_idx == REG_CONTROL) begin
                if (wb_sel_i[0]) begin
                    gt_reset_o  <= wr_word.ctrl.gt_reset;
                    powerdown_o <= wr_word.ctrl.powerdown;
                    loopback_o  <= wr_word.ctrl.loopback;
                end
                if (wb_sel_i[3]) err_clear_o <= wr_word.ctrl.err_clear;
            end
            if (wr_ack && reg_idx == REG_EYESCAN) begin
                if (wb_sel_i[0]) txdiffctrl_o   <= wr_word.eyescan.swing;
                if (wb_sel_i[1]) txprecursor_o  <= wr_word.eyescan.precursor;
                if (wb_sel_i[2]) txpostcursor_o <= wr_word.eyescan.postcursor;
            end
        end
    end

endmodule

// File: link_status_capture.sv
`timescale 1ns/10ps

module link_status_capture (
    input  logic        user_clk,
    input  logic        linkerr_reset_userclk,
    input  logic        err_clear_i,
    input  logic        lane_up_i,
    input  logic        channel_up_i,
    input  logic        tx_lock_i,
    input  logic        tx_resetdone_i,
    input  logic        rx_resetdone_i,
    input  logic        link_reset_i,
    input  logic        hard_err_i,
    input  logic        soft_err_i,
    input  logic        frame_err_i,
    output logic [31:0] status_o,
    output logic        lane_up_o,
    output logic [3:0]  hsk_stat_o
);

    // level flags, lowest first: lane, channel, lock, tx done, rx done, link reset
    logic [5:0] flag_q;
    // sticky hard, soft, frame errors
    logic [2:0] err_q;

    always_ff @(posedge user_clk) begin
        if (linkerr_reset_userclk) begin
            flag_q <= 6'd0;
        end else begin
            flag_q <= {link_reset_i, rx_resetdone_i, tx_resetdone_i,
                       tx_lock_i, channel_up_i, lane_up_i};
        end
    end

    // clear wins over a new error in the same cycle
    always_ff @(posedge user_clk) begin
        if (linkerr_reset_userclk || err_clear_i) begin
            err_q <= 3'd0;
        end else begin
            if (hard_err_i)  err_q[0] <= 1'b1;
            if (soft_err_i)  err_q[1] <= 1'b1;
            if (frame_err_i) err_q[2] <= 1'b1;
        end
    end

    // bit 2 and bit 7 stay zero
    assign status_o   = {21'd0, err_q, 1'b0, flag_q[5:2], 1'b0, flag_q[1:0]};
    assign lane_up_o  = flag_q[0];
    assign hsk_stat_o = status_o[3:0];

endmodule

// File: link_tx_arbiter.sv
`timescale 1ns/10ps

module link_tx_arbiter #(
    parameter int DATA_W = 32
) (
    input  logic                               user_clk,
    input  logic                               linkerr_reset_userclk,
    input  logic [DATA_W-1:0]                  s_axis_tdata_i,
    input  logic [aurora_link_pkg::KEEP_W-1:0] s_axis_tkeep_i,
    input  logic                               s_axis_tlast_i,
    input  logic                               s_axis_tvalid_i,
    output logic                               s_axis_tready_o,
    input  logic [DATA_W-1:0]                  s_ufc_tdata_i,
    input  logic                               s_ufc_tvalid_i,
    output logic                               s_ufc_tready_o,
    output logic [DATA_W-1:0]                  m_tx_tdata_o,
    output logic [aurora_link_pkg::KEEP_W-1:0] m_tx_tkeep_o,
    output logic                               m_tx_tlast_o,
    output logic                               m_tx_tvalid_o,
    input  logic                               m_tx_tready_i,
    output logic [2:0]                         m_ufc_tdata_o,
    output logic                               m_ufc_tvalid_o,
    input  logic                               m_ufc_tready_i
);
    import aurora_link_pkg::*;

    // high for the single cycle after a ufc request handshake
    logic ufc_cycle_q;

    always_ff @(posedge user_clk) begin
        if (linkerr_reset_userclk) begin
            ufc_cycle_q <= 1'b0;
        end else begin
            ufc_cycle_q <= m_ufc_tvalid_o && m_ufc_tready_i;
        end
    end

    // request is masked in the data cycle, so never two in a row
    assign m_ufc_tvalid_o = s_ufc_tvalid_i && !ufc_cycle_q;
    assign m_ufc_tdata_o  = UFC_SIZE_ONE_WORD;

    // the ufc word is popped as it goes out
    assign s_ufc_tready_o = ufc_cycle_q;

    // ufc word borrows the data lane for one cycle
    assign m_tx_tdata_o  = ufc_cycle_q ? s_ufc_tdata_i : s_axis_tdata_i;
    assign m_tx_tkeep_o  = s_axis_tkeep_i;
    assign m_tx_tlast_o  = s_axis_tlast_i;
    assign m_tx_tvalid_o = s_axis_tvalid_i && !ufc_cycle_q;

    // user data stalls for link back-pressure and for the ufc cycle
    assign s_axis_tready_o = m_tx_tready_i && !ufc_cycle_q;

endmodule

// File: link_uptime_counter.sv
`timescale 1ns/10ps

module link_uptime_counter #(
    parameter int UPTIME_W = 32
) (
    input  logic                user_clk,
    input  logic                linkerr_reset_userclk,
    input  logic                pps_i,
    input  logic                tx_ready_i,
    output logic [UPTIME_W-1:0] uptime_o
);

    logic [UPTIME_W-1:0] count_q;

    // pps cycle itself is never counted
    always_ff @(posedge user_clk) begin
        if (linkerr_reset_userclk) begin
            count_q <= '0;
        end else if (pps_i) begin
            count_q <= '0;
        end else if (tx_ready_i) begin
            count_q <= count_q + 1'b1;
        end
    end

    // count over the last full second
    always_ff @(posedge user_clk) begin
        if (linkerr_reset_userclk) begin
            uptime_o <= '0;
        end else if (pps_i) begin
            uptime_o <= count_q;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_aurora_link -f sim.f -Mdir obj_dir \
    || { echo "build failed"; exit 1; }
./obj_dir/Vtb_aurora_link | tee /dev/stderr | grep -q "All tests passed" \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }

// File: sim.f
aurora_link_pkg.sv
link_ctrl_regs.sv
link_status_capture.sv
link_uptime_counter.sv
link_tx_arbiter.sv
aurora_link_top.sv
aurora_link_sva.sv
tb_aurora_link.sv

// File: tb_aurora_link.sv
`timescale 1ns/10ps

module tb_aurora_link;
    import aurora_link_pkg::*;

    localparam int N_DATA = 60;
    localparam int N_UFC  = 12;

    logic user_clk = 1'b0;
    logic linkerr_reset_userclk;
    logic wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
    logic [3:0] wb_sel_i;
    logic [4:0] wb_adr_i;
    logic [31:0] wb_dat_i, wb_dat_o;
    logic hsk_rst_i, lane_up_o, pps_i;
    logic [3:0] hsk_stat_o;
    logic lane_up_i, channel_up_i, tx_lock_i, tx_resetdone_i, rx_resetdone_i;
    logic hard_err_i, soft_err_i, frame_err_i;
    logic [15:0] dmonitor_i;
    logic [31:0] s_axis_tdata_i, s_ufc_tdata_i, m_tx_tdata_o;
    logic [3:0] s_axis_tkeep_i, m_tx_tkeep_o;
    logic s_axis_tlast_i, s_axis_tvalid_i, s_axis_tready_o;
    logic s_ufc_tvalid_i, s_ufc_tready_o;
    logic m_tx_tlast_o, m_tx_tvalid_o, m_tx_tready_i;
    logic [2:0] m_ufc_tdata_o, loopback_o;
    logic m_ufc_tvalid_o, m_ufc_tready_i;
    logic link_reset_o, gt_reset_o, powerdown_o;
    logic [3:0] txdiffctrl_o;
    logic [4:0] txprecursor_o, txpostcursor_o;

    integer seed = 4;
    int errors = 0, checks = 0, tests = 0, test_err0 = 0;
    // register model
    reg_word_u ctrl_m, eye_m;
    logic [2:0] err_m;
    logic [31:0] data_w [N_DATA];
    logic [3:0] keep_w [N_DATA];
    logic last_w [N_DATA];
    logic [31:0] ufc_w [N_UFC];

    always #10 user_clk = ~user_clk;

    aurora_link_top DUT (.*);

    function automatic logic [31:0] rnd();
        rnd = $random(seed);
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s finished with %0d errors", tests, name, errors - test_err0);
        test_err0 = errors;
    endtask

    task automatic bus_access(input logic we, input logic [2:0] idx, input logic [31:0] data,
                              input logic [3:0] sel, output logic [31:0] rdata);
        int n;
        @(negedge user_clk);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = {idx, 2'b00};
        wb_dat_i = data;
        wb_sel_i = sel;
        n = 0;
        do begin
            @(posedge user_clk);
            n++;
        end while (!wb_ack_o && n < 10);
        if (!wb_ack_o) begin
            abort_run("register bus access got no ack");
        end else begin
            rdata = wb_dat_o;
            @(negedge user_clk);
            wb_cyc_i = 1'b0;
            wb_stb_i = 1'b0;
            wb_we_i  = 1'b0;
        end
    endtask

    task automatic reg_write(input logic [2:0] idx, input logic [31:0] data,
                             input logic [3:0] sel);
        reg_word_u w;
        logic [31:0] dummy;
        w.raw = data;
        bus_access(1'b1, idx, data, sel, dummy);
        if (idx == REG_CONTROL && sel[0]) begin
            ctrl_m.ctrl.gt_reset  = w.ctrl.gt_reset;
            ctrl_m.ctrl.powerdown = w.ctrl.powerdown;
            ctrl_m.ctrl.loopback  = w.ctrl.loopback;
        end
        if (idx == REG_CONTROL && sel[3]) ctrl_m.ctrl.err_clear = w.ctrl.err_clear;
        if (idx == REG_EYESCAN && sel[0]) eye_m.eyescan.swing = w.eyescan.swing;
        if (idx == REG_EYESCAN && sel[1]) eye_m.eyescan.precursor = w.eyescan.precursor;
        if (idx == REG_EYESCAN && sel[2]) eye_m.eyescan.postcursor = w.eyescan.postcursor;
    endtask

    // control and eye-scan pins against the register model
    task automatic compare_ctrl_pins();
        check("gt_reset_o", 32'(gt_reset_o), 32'(ctrl_m.ctrl.gt_reset));
        check("powerdown_o", 32'(powerdown_o), 32'(ctrl_m.ctrl.powerdown));
        check("loopback_o", 32'(loopback_o), 32'(ctrl_m.ctrl.loopback));
        check("txdiffctrl_o", 32'(txdiffctrl_o), 32'(eye_m.eyescan.swing));
        check("txprecursor_o", 32'(txprecursor_o), 32'(eye_m.eyescan.precursor));
        check("txpostcursor_o", 32'(txpostcursor_o), 32'(eye_m.eyescan.postcursor));
    endtask

    function automatic logic [31:0] expect_reg(input logic [2:0] idx);
        reg_word_u w;
        logic [2:0] b;
        case (idx)
            3'd5:    b = REG_STATUS;
            3'd6:    b = REG_EYESCAN;
            3'd7:    b = REG_DMONITOR;
            default: b = idx;
        endcase
        w.raw = '0;
        case (b)
            3'd0: begin
                w = ctrl_m;
                w.ctrl.link_reset = hsk_rst_i;
            end
            3'd1: w.raw = {21'd0, err_m, 1'b0, hsk_rst_i, rx_resetdone_i, tx_resetdone_i,
                           tx_lock_i, 1'b0, channel_up_i, lane_up_i};
            3'd2: w = eye_m;
            3'd3: w.raw = {16'd0, dmonitor_i};
            default: w.raw = '0;
        endcase
        return w.raw;
    endfunction

    task automatic read_check(input logic [2:0] idx);
        logic [31:0] rd;
        bus_access(1'b0, idx, 32'd0, 4'hf, rd);
        check($sformatf("wb_dat_o reg %0d", idx), rd, expect_reg(idx));
    endtask

    task automatic run_arbiter();
        int dptr = 0;
        int uptr = 0;
        int drx = 0;
        int urx = 0;
        int cyc = 0;
        logic pend = 1'b0;
        logic dtaken = 1'b0;
        logic utaken = 1'b0;
        logic [31:0] r;
        while ((drx < N_DATA || urx < N_UFC) && cyc < 3000) begin
            @(negedge user_clk);
            r = rnd();
            if (dtaken) begin
                s_axis_tvalid_i = 1'b0;
                dptr++;
            end
            if (utaken) begin
                s_ufc_tvalid_i = 1'b0;
                uptr++;
            end
            if (!s_axis_tvalid_i && dptr < N_DATA && r[0]) begin
                s_axis_tdata_i  = data_w[dptr];
                s_axis_tkeep_i  = keep_w[dptr];
                s_axis_tlast_i  = last_w[dptr];
                s_axis_tvalid_i = 1'b1;
            end
            if (!s_ufc_tvalid_i && uptr < N_UFC && r[3:1] == 3'd0) begin
                s_ufc_tdata_i  = ufc_w[uptr];
                s_ufc_tvalid_i = 1'b1;
            end
            m_tx_tready_i  = r[4] | r[5];
            m_ufc_tready_i = r[6];
            @(posedge user_clk);
            // sink side
            if (pend && urx < N_UFC) begin
                check("s_ufc_tready_o", 32'(s_ufc_tready_o), 32'd1);
                check("m_tx_tdata_o ufc", m_tx_tdata_o, ufc_w[urx]);
                urx++;
            end
            pend = m_ufc_tvalid_o && m_ufc_tready_i;
            if (pend) check("m_ufc_tdata_o", 32'(m_ufc_tdata_o), 32'd1);
            if (m_tx_tvalid_o && m_tx_tready_i && drx < N_DATA) begin
                check("m_tx_tdata_o", m_tx_tdata_o, data_w[drx]);
                check("m_tx_tkeep_o", 32'(m_tx_tkeep_o), 32'(keep_w[drx]));
                check("m_tx_tlast_o", 32'(m_tx_tlast_o), 32'(last_w[drx]));
                drx++;
            end
            dtaken = s_axis_tvalid_i && s_axis_tready_o;
            utaken = s_ufc_tvalid_i && s_ufc_tready_o;
            cyc++;
        end
        if (drx < N_DATA || urx < N_UFC) begin
            abort_run("arbiter test timed out before all words arrived");
        end else begin
            @(negedge user_clk);
            s_axis_tvalid_i = 1'b0;
            s_ufc_tvalid_i  = 1'b0;
            m_tx_tready_i   = 1'b0;
            m_ufc_tready_i  = 1'b0;
        end
    endtask

    initial begin
        logic [31:0] r, cnt, exp_up;
        linkerr_reset_userclk = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_sel_i = 4'd0;
        wb_adr_i = 5'd0;
        wb_dat_i = 32'd0;
        hsk_rst_i = 1'b0;
        pps_i     = 1'b0;
        {lane_up_i, channel_up_i, tx_lock_i, tx_resetdone_i, rx_resetdone_i} = 5'd0;
        {hard_err_i, soft_err_i, frame_err_i} = 3'd0;
        dmonitor_i = 16'h5a3c;
        s_axis_tdata_i  = 32'd0;
        s_axis_tkeep_i  = 4'd0;
        s_axis_tlast_i  = 1'b0;
        s_axis_tvalid_i = 1'b0;
        s_ufc_tdata_i   = 32'd0;
        s_ufc_tvalid_i  = 1'b0;
        m_tx_tready_i   = 1'b0;
        m_ufc_tready_i  = 1'b0;
        ctrl_m.raw = '0;
        eye_m.raw = '0;
        eye_m.eyescan.swing = TXDIFFCTRL_DEFAULT;
        err_m = 3'd0;
        for (int i = 0; i < N_DATA; i++) begin
            data_w[i] = rnd();
            r = rnd();
            keep_w[i] = r[3:0];
            last_w[i] = r[4];
        end
        for (int i = 0; i < N_UFC; i++) ufc_w[i] = rnd();
        repeat (5) @(posedge user_clk);
        @(negedge user_clk);
        linkerr_reset_userclk = 1'b0;

        check("wb_ack_o", 32'(wb_ack_o), 32'd0);
        check("link_reset_o", 32'(link_reset_o), 32'd0);
        check("m_ufc_tvalid_o", 32'(m_ufc_tvalid_o), 32'd0);
        check("s_ufc_tready_o", 32'(s_ufc_tready_o), 32'd0);
        check("txdiffctrl_o", 32'(txdiffctrl_o), 32'd8);
        compare_ctrl_pins();
        for (int i = 0; i < 8; i++) read_check(3'(i));
        for (int i = 0; i < 12; i++) begin
            r = rnd();
            // bit 0 left clear so hsk_rst_i keeps link reset
            reg_write(r[0] ? REG_EYESCAN : REG_CONTROL, rnd() & 32'hffff_fffe, r[7:4]);
            compare_ctrl_pins();
            for (int j = 0; j < 8; j++) read_check(3'(j));
        end
        reg_write(REG_CONTROL, 32'd0, 4'hf);
        compare_ctrl_pins();
        read_check(REG_CONTROL);
        end_test("register writes and reads");

        for (int i = 0; i < 4; i++) begin
            @(negedge user_clk);
            hsk_rst_i = ~hsk_rst_i;
            @(negedge user_clk);
            check("link_reset_o", 32'(link_reset_o), 32'(hsk_rst_i));
            read_check(REG_CONTROL);
        end
        end_test("housekeeping reset");

        @(negedge user_clk);
        r = rnd();
        {rx_resetdone_i, tx_resetdone_i, tx_lock_i, channel_up_i, lane_up_i} = r[4:0];
        for (int i = 0; i < 20; i++) begin
            @(negedge user_clk);
            r = rnd();
            hard_err_i  = r[0] & r[1];
            soft_err_i  = r[2] & r[3];
            frame_err_i = r[4] & r[5];
            err_m = err_m | {frame_err_i, soft_err_i, hard_err_i};
        end
        @(negedge user_clk);
        {hard_err_i, soft_err_i, frame_err_i} = 3'd0;
        read_check(REG_STATUS);
        read_check(3'd5);
        check("hsk_stat_o", 32'(hsk_stat_o), 32'(expect_reg(REG_STATUS) & 32'hf));
        check("lane_up_o", 32'(lane_up_o), 32'(lane_up_i));
        reg_write(REG_CONTROL, 32'h8000_0000, 4'h8);
        err_m = 3'd0;
        read_check(REG_STATUS);
        reg_write(REG_CONTROL, 32'd0, 4'h8);
        read_check(REG_STATUS);
        end_test("sticky errors");

        run_arbiter();
        end_test("arbiter ordering");

        cnt = 0;
        exp_up = 0;
        for (int i = 0; i < 300; i++) begin
            @(negedge user_clk);
            r = rnd();
            pps_i = (i == 5) || (i == 299) || (r[4:0] == 5'd0);
            m_tx_tready_i = r[5];
            @(posedge user_clk);
            if (pps_i) begin
                exp_up = cnt;
                cnt = 0;
            end else if (m_tx_tready_i) begin
                cnt++;
            end
        end
        @(negedge user_clk);
        pps_i = 1'b0;
        begin
            logic [31:0] rd;
            bus_access(1'b0, REG_UPTIME, 32'd0, 4'hf, rd);
            check("wb_dat_o uptime", rd, exp_up);
        end
        end_test("uptime");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
